// ==== logic/stq_pkg.sv ====
package stq_pkg;

    localparam int ROB_ID_W   = 6;
    localparam int PIPE_DEPTH = 5;

    typedef logic [ROB_ID_W-1:0] rob_id_t;  // Ages wrap modulo 64.
    typedef logic [15:0]         addr_t;
    typedef logic [31:0]         data_t;
    typedef logic [1:0]          size_t;    // 1, 2, 4 or 4 bytes.

    typedef enum logic {
        pipe_complete,
        pipe_replay
    } pipe_action_e;

    typedef enum logic [1:0] {
        e_idle,
        e_alloc,      // Holds robid and size, waits for issue.
        e_ready,      // Address and data known.
        e_inflight
    } entry_state_e;

endpackage

// ==== logic/stq_entry.sv ====
`timescale 1ns/1ps

module stq_entry (
    input  logic            clk,
    input  logic            rst,
    input  logic            alloc,
    input  stq_pkg::rob_id_t alloc_robid,
    input  stq_pkg::size_t  alloc_size,
    input  logic            issue,
    input  stq_pkg::addr_t  iss_addr,
    input  stq_pkg::data_t  iss_data,
    input  logic            flush_valid,
    input  stq_pkg::rob_id_t flush_robid,
    input  stq_pkg::rob_id_t oldest_robid,
    input  stq_pkg::rob_id_t commit_robid,
    input  logic            gnt,
    input  logic            done,
    input  logic            replay,
    output logic            valid,
    output logic            req,
    output stq_pkg::rob_id_t robid,
    output stq_pkg::addr_t  addr,
    output stq_pkg::data_t  data,
    output stq_pkg::size_t  size
);

    stq_pkg::entry_state_e state;
    stq_pkg::rob_id_t      my_age;
    stq_pkg::rob_id_t      commit_age;
    stq_pkg::rob_id_t      flush_age;
    logic                  committed;
    logic                  flushed;

    // Distances from the oldest robid, wrapping in 6 bits.
    assign my_age     = robid - oldest_robid;
    assign commit_age = commit_robid - oldest_robid;
    assign flush_age  = flush_robid - oldest_robid;

    assign committed = my_age < commit_age;
    assign flushed   = flush_valid && valid && (my_age >= flush_age);

    assign valid = state != stq_pkg::e_idle;
    assign req   = (state == stq_pkg::e_ready) && committed;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stq_pkg::e_idle;
        end else if (flushed) begin
            state <= stq_pkg::e_idle;  // Pipe report for it is ignored later.
        end else begin
            case (state)
                stq_pkg::e_idle: begin
                    if (alloc) state <= stq_pkg::e_alloc;
                end
                stq_pkg::e_alloc: begin
                    if (issue) state <= stq_pkg::e_ready;
                end
                stq_pkg::e_ready: begin
                    if (req && gnt) state <= stq_pkg::e_inflight;
                end
                stq_pkg::e_inflight: begin
                    if (done) begin
                        state <= stq_pkg::e_idle;
                    end else if (replay) begin
                        state <= stq_pkg::e_ready;  // Ask again.
                    end
                end
                default: state <= stq_pkg::e_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            robid <= alloc_robid;
            size  <= alloc_size;
        end
        if (issue) begin
            addr <= iss_addr;
            data <= iss_data;
        end
    end

endmodule

// ==== logic/age_matrix.sv ====
`timescale 1ns/1ps

module age_matrix #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [STQ_ENTRIES-1:0] alloc,
    input  logic [STQ_ENTRIES-1:0] reqs,
    output logic [STQ_ENTRIES-1:0] oldest_sel
);

    // Row i holds the entries allocated before entry i.
    logic [STQ_ENTRIES-1:0] elders [STQ_ENTRIES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STQ_ENTRIES; i++) begin
                elders[i] <= '0;
            end
        end else begin
            for (int i = 0; i < STQ_ENTRIES; i++) begin
                if (alloc[i]) begin
                    elders[i] <= ~alloc;  // Everyone else is older.
                end else begin
                    elders[i] <= elders[i] & ~alloc;  // Newcomer is younger.
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            oldest_sel[i] = reqs[i] && !(|(elders[i] & reqs));
        end
    end

endmodule

// ==== logic/store_queue.sv ====
`timescale 1ns/1ps

module store_queue #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   disp_valid,
    input  logic                   disp_is_store,
    input  stq_pkg::rob_id_t       disp_robid,
    input  stq_pkg::size_t         disp_size,
    output logic [$clog2(STQ_ENTRIES)-1:0] stq_id,
    input  logic                   iss_valid,
    input  logic                   iss_is_store,
    input  logic [$clog2(STQ_ENTRIES)-1:0] iss_stq_id,
    input  stq_pkg::addr_t         iss_addr,
    input  stq_pkg::data_t         iss_data,
    input  logic                   flush_valid,
    input  stq_pkg::rob_id_t       flush_robid,
    input  stq_pkg::rob_id_t       oldest_robid,
    input  stq_pkg::rob_id_t       commit_robid,
    output logic                   full,
    output logic                   idle,
    output logic                   pipe_req,
    input  logic                   pipe_gnt,
    output logic [$clog2(STQ_ENTRIES)-1:0] pipe_stq_id,
    output stq_pkg::addr_t         pipe_addr,
    output stq_pkg::data_t         pipe_data,
    output stq_pkg::size_t         pipe_size,
    output stq_pkg::rob_id_t       pipe_robid,
    input  logic                   pipe_valid_mm5,
    input  logic [$clog2(STQ_ENTRIES)-1:0] pipe_stq_id_mm5,
    input  stq_pkg::pipe_action_e  pipe_action_mm5
);

    localparam int ID_W = $clog2(STQ_ENTRIES);
    typedef logic [ID_W-1:0] stq_id_t;

    logic                   disp_ok;
    logic                   iss_ok;
    logic [STQ_ENTRIES-1:0] free_sel;
    logic [STQ_ENTRIES-1:0] alloc;
    logic [STQ_ENTRIES-1:0] e_valid;
    logic [STQ_ENTRIES-1:0] e_req;
    logic [STQ_ENTRIES-1:0] e_sel;
    stq_pkg::rob_id_t       e_robid [STQ_ENTRIES];
    stq_pkg::addr_t         e_addr  [STQ_ENTRIES];
    stq_pkg::data_t         e_data  [STQ_ENTRIES];
    stq_pkg::size_t         e_size  [STQ_ENTRIES];

    // Dispatch and issue are dropped during a flush.
    assign disp_ok = disp_valid && disp_is_store && !flush_valid && !full;
    assign iss_ok  = iss_valid && iss_is_store && !flush_valid;

    always_comb begin
        free_sel = '0;
        stq_id   = '0;
        for (int i = STQ_ENTRIES - 1; i >= 0; i--) begin
            if (!e_valid[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;
                stq_id      = stq_id_t'(i);  // Lowest free wins.
            end
        end
    end

    assign alloc = disp_ok ? free_sel : '0;

    age_matrix #(.STQ_ENTRIES(STQ_ENTRIES)) age_i (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .reqs       (e_req),
        .oldest_sel (e_sel)
    );

    for (genvar e = 0; e < STQ_ENTRIES; e++) begin : g_entries
        stq_entry entry_i (
            .clk          (clk),
            .rst          (rst),
            .alloc        (alloc[e]),
            .alloc_robid  (disp_robid),
            .alloc_size   (disp_size),
            .issue        (iss_ok && (iss_stq_id == stq_id_t'(e))),
            .iss_addr     (iss_addr),
            .iss_data     (iss_data),
            .flush_valid  (flush_valid),
            .flush_robid  (flush_robid),
            .oldest_robid (oldest_robid),
            .commit_robid (commit_robid),
            .gnt          (pipe_gnt && e_sel[e]),
            .done         (pipe_valid_mm5 && (pipe_stq_id_mm5 == stq_id_t'(e))
                           && (pipe_action_mm5 == stq_pkg::pipe_complete)),
            .replay       (pipe_valid_mm5 && (pipe_stq_id_mm5 == stq_id_t'(e))
                           && (pipe_action_mm5 == stq_pkg::pipe_replay)),
            .valid        (e_valid[e]),
            .req          (e_req[e]),
            .robid        (e_robid[e]),
            .addr         (e_addr[e]),
            .data         (e_data[e]),
            .size         (e_size[e])
        );
    end

    always_comb begin
        pipe_stq_id = '0;
        pipe_addr   = '0;
        pipe_data   = '0;
        pipe_size   = '0;
        pipe_robid  = '0;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (e_sel[i]) begin
                pipe_stq_id = stq_id_t'(i);
                pipe_addr   = e_addr[i];
                pipe_data   = e_data[i];
                pipe_size   = e_size[i];
                pipe_robid  = e_robid[i];
            end
        end
    end

    assign pipe_req = |e_sel;
    assign idle     = ~|e_valid;
    assign full     = &e_valid;

endmodule

// ==== logic/mem_pipe.sv ====
`timescale 1ns/1ps

module mem_pipe #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic [$clog2(STQ_ENTRIES)-1:0] req_stq_id,
    input  stq_pkg::addr_t         req_addr,
    input  stq_pkg::data_t         req_data,
    input  stq_pkg::size_t         req_size,
    input  stq_pkg::rob_id_t       req_robid,
    input  logic                   pipe_stall,
    input  logic                   mem_busy,
    output logic                   gnt,
    output logic                   valid_mm5,
    output logic [$clog2(STQ_ENTRIES)-1:0] stq_id_mm5,
    output stq_pkg::pipe_action_e  action_mm5,
    output logic                   wr_valid,
    output stq_pkg::addr_t         wr_addr,
    output stq_pkg::data_t         wr_data,
    output stq_pkg::size_t         wr_size,
    output stq_pkg::rob_id_t       wr_robid
);

    localparam int DEPTH = stq_pkg::PIPE_DEPTH;
    localparam int LAST  = DEPTH - 1;
    typedef logic [$clog2(STQ_ENTRIES)-1:0] stq_id_t;

    logic [DEPTH-1:0] stg_valid;
    stq_id_t          stg_id    [DEPTH];
    stq_pkg::addr_t   stg_addr  [DEPTH];
    stq_pkg::data_t   stg_data  [DEPTH];
    stq_pkg::size_t   stg_size  [DEPTH];
    stq_pkg::rob_id_t stg_robid [DEPTH];

    assign gnt = !pipe_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            stg_valid <= '0;
        end else begin
            stg_valid <= {stg_valid[DEPTH-2:0], req && gnt};
        end
    end

    always_ff @(posedge clk) begin
        stg_id[0]    <= req_stq_id;
        stg_addr[0]  <= req_addr;
        stg_data[0]  <= req_data;
        stg_size[0]  <= req_size;
        stg_robid[0] <= req_robid;
        for (int s = 1; s < DEPTH; s++) begin
            stg_id[s]    <= stg_id[s-1];
            stg_addr[s]  <= stg_addr[s-1];
            stg_data[s]  <= stg_data[s-1];
            stg_size[s]  <= stg_size[s-1];
            stg_robid[s] <= stg_robid[s-1];
        end
    end

    // Busy memory at mm5 bounces the store.
    assign valid_mm5  = stg_valid[LAST];
    assign stq_id_mm5 = stg_id[LAST];
    assign action_mm5 = mem_busy ? stq_pkg::pipe_replay : stq_pkg::pipe_complete;

    assign wr_valid = stg_valid[LAST] && !mem_busy;
    assign wr_addr  = stg_addr[LAST];
    assign wr_data  = stg_data[LAST];
    assign wr_size  = stg_size[LAST];
    assign wr_robid = stg_robid[LAST];

endmodule

// ==== logic/stq_top.sv ====
`timescale 1ns/1ps

module stq_top #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   disp_valid,
    input  logic                   disp_is_store,
    input  stq_pkg::rob_id_t       disp_robid,
    input  stq_pkg::size_t         disp_size,
    output logic [$clog2(STQ_ENTRIES)-1:0] stq_id,
    input  logic                   iss_valid,
    input  logic                   iss_is_store,
    input  logic [$clog2(STQ_ENTRIES)-1:0] iss_stq_id,
    input  stq_pkg::addr_t         iss_addr,
    input  stq_pkg::data_t         iss_data,
    input  logic                   flush_valid,
    input  stq_pkg::rob_id_t       flush_robid,
    input  stq_pkg::rob_id_t       oldest_robid,
    input  stq_pkg::rob_id_t       commit_robid,
    input  logic                   pipe_stall,
    input  logic                   mem_busy,
    output logic                   wr_valid,
    output stq_pkg::addr_t         wr_addr,
    output stq_pkg::data_t         wr_data,
    output stq_pkg::size_t         wr_size,
    output stq_pkg::rob_id_t       wr_robid,
    output logic                   full,
    output logic                   idle
);

    typedef logic [$clog2(STQ_ENTRIES)-1:0] stq_id_t;

    logic                  pipe_req;
    logic                  pipe_gnt;
    stq_id_t               pipe_stq_id;
    stq_pkg::addr_t        pipe_addr;
    stq_pkg::data_t        pipe_data;
    stq_pkg::size_t        pipe_size;
    stq_pkg::rob_id_t      pipe_robid;
    logic                  pipe_valid_mm5;
    stq_id_t               pipe_stq_id_mm5;
    stq_pkg::pipe_action_e pipe_action_mm5;

    store_queue #(.STQ_ENTRIES(STQ_ENTRIES)) stq_i (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_is_store   (disp_is_store),
        .disp_robid      (disp_robid),
        .disp_size       (disp_size),
        .stq_id          (stq_id),
        .iss_valid       (iss_valid),
        .iss_is_store    (iss_is_store),
        .iss_stq_id      (iss_stq_id),
        .iss_addr        (iss_addr),
        .iss_data        (iss_data),
        .flush_valid     (flush_valid),
        .flush_robid     (flush_robid),
        .oldest_robid    (oldest_robid),
        .commit_robid    (commit_robid),
        .full            (full),
        .idle            (idle),
        .pipe_req        (pipe_req),
        .pipe_gnt        (pipe_gnt),
        .pipe_stq_id     (pipe_stq_id),
        .pipe_addr       (pipe_addr),
        .pipe_data       (pipe_data),
        .pipe_size       (pipe_size),
        .pipe_robid      (pipe_robid),
        .pipe_valid_mm5  (pipe_valid_mm5),
        .pipe_stq_id_mm5 (pipe_stq_id_mm5),
        .pipe_action_mm5 (pipe_action_mm5)
    );

    mem_pipe #(.STQ_ENTRIES(STQ_ENTRIES)) pipe_i (
        .clk        (clk),
        .rst        (rst),
        .req        (pipe_req),
        .req_stq_id (pipe_stq_id),
        .req_addr   (pipe_addr),
        .req_data   (pipe_data),
        .req_size   (pipe_size),
        .req_robid  (pipe_robid),
        .pipe_stall (pipe_stall),
        .mem_busy   (mem_busy),
        .gnt        (pipe_gnt),
        .valid_mm5  (pipe_valid_mm5),
        .stq_id_mm5 (pipe_stq_id_mm5),
        .action_mm5 (pipe_action_mm5),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_size    (wr_size),
        .wr_robid   (wr_robid)
    );

endmodule

// ==== dv/stq_tb.sv ====
`timescale 1ns/1ps

module stq_tb;

    localparam int STQ_ENTRIES     = 8;
    localparam int ID_W            = $clog2(STQ_ENTRIES);
    localparam int CYCLES_PER_LINE = 200;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  disp_valid;
    logic                  disp_is_store;
    stq_pkg::rob_id_t      disp_robid;
    stq_pkg::size_t        disp_size;
    logic [ID_W-1:0]       stq_id;
    logic                  iss_valid;
    logic                  iss_is_store;
    logic [ID_W-1:0]       iss_stq_id;
    stq_pkg::addr_t        iss_addr;
    stq_pkg::data_t        iss_data;
    logic                  flush_valid;
    stq_pkg::rob_id_t      flush_robid;
    stq_pkg::rob_id_t      oldest_robid;
    stq_pkg::rob_id_t      commit_robid;
    logic                  pipe_stall;
    logic                  mem_busy;
    logic                  wr_valid;
    stq_pkg::addr_t        wr_addr;
    stq_pkg::data_t        wr_data;
    stq_pkg::size_t        wr_size;
    stq_pkg::rob_id_t      wr_robid;
    logic                  full;
    logic                  idle;

    logic             slot_busy  [STQ_ENTRIES];  // Lowest-free model of the queue.
    stq_pkg::rob_id_t slot_robid [STQ_ENTRIES];
    int               rob_slot   [64];
    int               iss_cycle  [64];
    int               lat_of     [64];

    string       cmd_op [$];
    logic [31:0] cmd_a0 [$];
    logic [31:0] cmd_a1 [$];
    logic [31:0] cmd_a2 [$];
    logic [31:0] cmd_a3 [$];
    logic [31:0] exp_robid [$];  // Expected writes, in file order.
    logic [31:0] exp_addr  [$];
    logic [31:0] exp_data  [$];
    logic [31:0] exp_size  [$];

    int         n_lines;
    bit         loaded;
    bit         shuffled;  // Set once stall or busy windows start.
    int         cycle;
    int         stall_left;
    int         busy_left;
    logic [7:0] lfsr;

    stq_top #(.STQ_ENTRIES(STQ_ENTRIES)) dut_i (
        .clk           (clk),
        .rst           (rst),
        .disp_valid    (disp_valid),
        .disp_is_store (disp_is_store),
        .disp_robid    (disp_robid),
        .disp_size     (disp_size),
        .stq_id        (stq_id),
        .iss_valid     (iss_valid),
        .iss_is_store  (iss_is_store),
        .iss_stq_id    (iss_stq_id),
        .iss_addr      (iss_addr),
        .iss_data      (iss_data),
        .flush_valid   (flush_valid),
        .flush_robid   (flush_robid),
        .oldest_robid  (oldest_robid),
        .commit_robid  (commit_robid),
        .pipe_stall    (pipe_stall),
        .mem_busy      (mem_busy),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_size       (wr_size),
        .wr_robid      (wr_robid),
        .full          (full),
        .idle          (idle)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            fail_run($sformatf("mismatch at %0d ns: %s got %0h expected %0h",
                               $time, name, got, want));
        end
    endtask

    // Taps 8, 6, 5, 4.
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int busy_count();
        int n;
        n = 0;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (slot_busy[i]) n++;
        end
        return n;
    endfunction

    function automatic int lowest_free();
        int found;
        found = -1;
        for (int i = STQ_ENTRIES - 1; i >= 0; i--) begin
            if (!slot_busy[i]) found = i;
        end
        return found;
    endfunction

    // Removes every store at or younger than the flush point.
    function automatic void drop_flushed(input stq_pkg::rob_id_t f);
        stq_pkg::rob_id_t cut;
        stq_pkg::rob_id_t age;
        cut = f - oldest_robid;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            age = slot_robid[i] - oldest_robid;
            if (slot_busy[i] && age >= cut) slot_busy[i] = 1'b0;
        end
    endfunction

    task automatic match_write();
        stq_pkg::rob_id_t r;
        int               idx;
        r   = wr_robid;
        idx = -1;
        if (!shuffled && exp_robid.size() > 0) check("wr_robid", 32'(r), exp_robid[0]);
        for (int i = 0; i < exp_robid.size(); i++) begin
            if (idx < 0 && exp_robid[i] == 32'(r)) idx = i;
        end
        if (idx < 0) fail_run($sformatf("unexpected write for robid %0h at %0d ns", r, $time));
        check("wr_addr", 32'(wr_addr), exp_addr[idx]);
        check("wr_data", wr_data, exp_data[idx]);
        check("wr_size", 32'(wr_size), exp_size[idx]);
        if (lat_of[r] != 0) check("write latency", 32'(cycle - iss_cycle[r]), 32'(lat_of[r]));
        slot_busy[rob_slot[r]] = 1'b0;  // Entry frees at the coming edge.
        exp_robid.delete(idx);
        exp_addr.delete(idx);
        exp_data.delete(idx);
        exp_size.delete(idx);
    endtask

    task automatic begin_cycle();
        @(negedge clk);
        check("full", 32'(full), 32'(busy_count() == STQ_ENTRIES));
        check("idle", 32'(idle), 32'(busy_count() == 0));
        disp_valid    = 1'b0;
        disp_is_store = 1'b0;
        iss_valid     = 1'b0;
        iss_is_store  = 1'b0;
        flush_valid   = 1'b0;
        pipe_stall    = 1'b0;
        mem_busy      = 1'b0;
        if (stall_left > 0) begin
            lfsr       = lfsr_step(lfsr);
            pipe_stall = lfsr[0];
            stall_left--;
        end
        if (busy_left > 0) begin
            lfsr     = lfsr_step(lfsr);
            mem_busy = lfsr[0];
            busy_left--;
        end
    endtask

    task automatic end_cycle();
        #1;  // Outputs settle after the falling-edge drive.
        if (wr_valid) match_write();
        @(posedge clk);
        cycle++;
    endtask

    task automatic load_golden();
        int          fd;
        int          rc;
        string       word;
        string       rest;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        fd = $fopen("dv/stq_golden.txt", "r");
        if (fd == 0) fail_run("could not open dv/stq_golden.txt");
        while ($fscanf(fd, "%s", word) == 1) begin
            a0 = '0;
            a1 = '0;
            a2 = '0;
            a3 = '0;
            if (word.getc(0) == "#") begin
                rc = $fgets(rest, fd);
                continue;
            end
            n_lines++;
            if (word == "disp") begin
                rc = $fscanf(fd, "%h %h", a0, a1);
            end else if (word == "issue") begin
                rc = $fscanf(fd, "%h %h %h %d", a0, a1, a2, a3);
            end else if (word == "commit" || word == "flush") begin
                rc = $fscanf(fd, "%h", a0);
            end else if (word == "stall" || word == "busy") begin
                rc = $fscanf(fd, "%d", a0);
            end else if (word == "write") begin
                rc = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                exp_robid.push_back(a0);
                exp_addr.push_back(a1);
                exp_data.push_back(a2);
                exp_size.push_back(a3);
                continue;
            end else if (word != "wait") begin
                fail_run($sformatf("unknown command %s in the golden file", word));
            end
            cmd_op.push_back(word);
            cmd_a0.push_back(a0);
            cmd_a1.push_back(a1);
            cmd_a2.push_back(a2);
            cmd_a3.push_back(a3);
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    task automatic run_command(input string op, input logic [31:0] a0, input logic [31:0] a1,
                               input logic [31:0] a2, input logic [31:0] a3);
        int slot;
        slot = 0;
        if (op == "wait") begin
            begin_cycle();
            while (!idle) begin
                end_cycle();
                begin_cycle();
            end
            end_cycle();
        end else begin
            begin_cycle();
            if (op == "disp") begin
                slot              = lowest_free();
                disp_valid        = 1'b1;
                disp_is_store     = 1'b1;
                disp_robid        = a0[5:0];
                disp_size         = a1[1:0];
                slot_busy[slot]   = 1'b1;
                slot_robid[slot]  = a0[5:0];
                rob_slot[a0[5:0]] = slot;
            end else if (op == "issue") begin
                iss_valid          = 1'b1;
                iss_is_store       = 1'b1;
                iss_stq_id         = ID_W'(rob_slot[a0[5:0]]);
                iss_addr           = a1[15:0];
                iss_data           = a2;
                iss_cycle[a0[5:0]] = cycle;
                lat_of[a0[5:0]]    = int'(a3);
            end else if (op == "commit") begin
                commit_robid = a0[5:0];
            end else if (op == "flush") begin
                flush_valid = 1'b1;
                flush_robid = a0[5:0];
                drop_flushed(a0[5:0]);
            end else if (op == "stall") begin
                stall_left = int'(a0);
                shuffled   = 1'b1;
            end else if (op == "busy") begin
                busy_left = int'(a0);
                shuffled  = 1'b1;
            end
            #1;
            if (op == "disp") check("stq_id", 32'(stq_id), 32'(slot));
            end_cycle();
        end
    endtask

    initial begin
        rst           = 1'b1;
        disp_valid    = 1'b0;
        disp_is_store = 1'b0;
        disp_robid    = '0;
        disp_size     = '0;
        iss_valid     = 1'b0;
        iss_is_store  = 1'b0;
        iss_stq_id    = '0;
        iss_addr      = '0;
        iss_data      = '0;
        flush_valid   = 1'b0;
        flush_robid   = '0;
        oldest_robid  = '0;  // Ages are measured from robid zero.
        commit_robid  = '0;
        pipe_stall    = 1'b0;
        mem_busy      = 1'b0;
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            slot_busy[i]  = 1'b0;
            slot_robid[i] = '0;
        end
        lfsr       = 8'd51;
        cycle      = 0;
        stall_left = 0;
        busy_left  = 0;
        shuffled   = 1'b0;
        n_lines    = 0;
        load_golden();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < cmd_op.size(); i++) begin
            run_command(cmd_op[i], cmd_a0[i], cmd_a1[i], cmd_a2[i], cmd_a3[i]);
        end
        if (exp_robid.size() == 0 && idle) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected writes never arrived", exp_robid.size()));
        end
    end

    initial begin
        wait (loaded);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
        fail_run($sformatf("run timed out after %0d cycles", n_lines * CYCLES_PER_LINE));
    end

endmodule

// ==== dv/stq_golden.txt ====
# disp robid size | issue robid addr data latency | commit robid | flush robid | wait
# stall cycles | busy cycles | write robid addr data size; cycles and latency decimal, rest hex
disp 01 0
disp 02 1
disp 03 2
disp 04 3
disp 05 2
disp 06 1
disp 07 0
disp 08 2
commit 09
issue 01 1000 11110001 6
issue 02 1004 22220002 6
issue 03 1008 33330003 6
issue 04 100c 44440004 6
issue 05 2000 55550005 6
issue 06 2002 66660006 6
issue 07 2005 77770007 6
issue 08 2010 88880008 6
wait
write 01 1000 11110001 0
write 02 1004 22220002 1
write 03 1008 33330003 2
write 04 100c 44440004 3
write 05 2000 55550005 2
write 06 2002 66660006 1
write 07 2005 77770007 0
write 08 2010 88880008 2
# Held back until the commit pointer passes 0a.
disp 0a 2
issue 0a 3000 aaaa000a 9
commit 0a
commit 0a
commit 0a
commit 0b
wait
write 0a 3000 aaaa000a 2
# Flush drops 12 and 13, then 14 and 15 take slots 2 and 3.
disp 10 2
disp 11 1
disp 12 2
disp 13 0
issue 10 4000 d00d0010 0
issue 11 4002 d00d0011 0
flush 12
disp 14 2
disp 15 3
issue 14 4010 d00d0014 0
issue 15 4014 d00d0015 0
commit 16
wait
write 10 4000 d00d0010 2
write 11 4002 d00d0011 1
write 14 4010 d00d0014 2
write 15 4014 d00d0015 3
# Random stall and busy windows, matched by robid.
stall 60
busy 60
disp 20 2
disp 21 1
disp 22 0
disp 23 2
issue 20 5000 c0de0020 0
issue 21 5002 c0de0021 0
issue 22 5003 c0de0022 0
issue 23 5008 c0de0023 0
commit 24
wait
write 22 5003 c0de0022 0
write 20 5000 c0de0020 2
write 23 5008 c0de0023 2
write 21 5002 c0de0021 1

// ==== store_queue.f ====
logic/stq_pkg.sv
logic/stq_entry.sv
logic/age_matrix.sv
logic/store_queue.sv
logic/mem_pipe.sv
logic/stq_top.sv
dv/stq_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module stq_tb -Mdir obj_dir -f store_queue.f

out=$(./obj_dir/Vstq_tb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '=== PASS ==='; then
    exit 0
fi
exit 1
